// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST)) lsu_cfg.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: data_ram.sv
// RAM contents are not cleared by reset; a read and a write never share an edge
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module data_ram
	import lsu_op_pkg::*, lsu_resp_pkg::*;
(
	input  wire                               clock,
	input  wire                               reset,
	input  wire                               al_valid,
	output logic                              al_ready,
	input  wire mem_op_e                      al_op,
	input  wire [$clog2(`LSU_MEM_WORDS)-1:0]  al_index,
	input  wire [2:0]                         al_offset,
	input  wire [`LSU_XLEN-1:0]               al_wdata,
	input  wire [`LSU_XLEN/8-1:0]             al_wmask,
	input  wire resp_code_e                   al_code,
	output logic                              rd_valid,
	input  wire                               rd_ready,
	output mem_op_e                           rd_op,
	output logic [2:0]                        rd_offset,
	output logic [`LSU_XLEN-1:0]              rd_word,
	output resp_code_e                        rd_code
);

	typedef enum logic {
		slot_empty = 1'b0,
		slot_full  = 1'b1
	} slot_state_e;

	slot_state_e          state;
	logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];
	logic                 al_fire;
	logic                 is_store;
	logic                 access_ok;

	assign al_ready  = (state == slot_empty) || rd_ready;
	assign rd_valid  = (state == slot_full);
	assign al_fire   = al_valid && al_ready;
	assign is_store  = al_op inside {op_sb, op_sh, op_sw, op_sd};
	assign access_ok = (al_code == resp_ok);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= slot_empty;
		end else if (al_ready) begin
			state <= al_valid ? slot_full : slot_empty;
		end
	end

	// byte-masked write
	always_ff @(posedge clock) begin
		if (al_fire && is_store && access_ok) begin
			for (int b = 0; b < `LSU_XLEN/8; b++) begin
				if (al_wmask[b]) begin
					mem[al_index][b*8 +: 8] <= al_wdata[b*8 +: 8];
				end
			end
		end
	end

	// synchronous read into the output slot
	always_ff @(posedge clock) begin
		if (al_fire) begin
			rd_op     <= al_op;
			rd_offset <= al_offset;
			rd_code   <= al_code;
			if (!is_store && access_ok) begin
				rd_word <= mem[al_index];
			end else begin
				rd_word <= '0;
			end
		end
	end

	// faulted requests leave the addressed word as it was
	a_no_write_on_error: assert property (@(posedge clock) disable iff (reset)
		(al_fire && !access_ok) |=> (mem[$past(al_index)] == $past(mem[al_index])))
		else $error("data_ram: word changed by a request with an error code");

endmodule

`default_nettype wire

// File: load_extract.sv
// stores and faulted requests answer with zero data
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module load_extract
	import lsu_op_pkg::*, lsu_resp_pkg::*;
(
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  rd_valid,
	output logic                 rd_ready,
	input  wire mem_op_e         rd_op,
	input  wire [2:0]            rd_offset,
	input  wire [`LSU_XLEN-1:0]  rd_word,
	input  wire resp_code_e      rd_code,
	output logic                 resp_valid,
	input  wire                  resp_ready,
	output logic [`LSU_XLEN-1:0] resp_data,
	output resp_code_e           resp_code
);

	logic [`LSU_XLEN-1:0] shifted;
	logic [`LSU_XLEN-1:0] extended;

	assign rd_ready = !resp_valid || resp_ready;

	// addressed bytes down to bit 0
	assign shifted = rd_word >> {rd_offset, 3'b000};

	always_comb begin
		case (rd_op)
			op_lb:   extended = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
			op_lbu:  extended = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
			op_lh:   extended = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
			op_lhu:  extended = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
			op_lw:   extended = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
			op_lwu:  extended = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
			op_ld:   extended = shifted;
			default: extended = '0;
		endcase
		if (rd_code != resp_ok) begin
			extended = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else if (rd_ready) begin
			resp_valid <= rd_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (rd_valid && rd_ready) begin
			resp_data <= extended;
			resp_code <= rd_code;
		end
	end

	// response held while stalled
	a_resp_hold: assert property (@(posedge clock) disable iff (reset)
		(resp_valid && !resp_ready) |=>
		(resp_valid && $stable(resp_data) && $stable(resp_code)))
		else $error("load_extract: response changed while stalled");

endmodule

`default_nettype wire

// File: lsu_cfg.svh
// sizes are fixed for a 64-bit core; base must be 8-byte aligned and depth a power of two
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data and address width in bits
`define LSU_XLEN 64

// RAM depth in words of LSU_XLEN bits
`define LSU_MEM_WORDS 256

// byte address of word 0, same as the core's start address
`define LSU_MEM_BASE 64'h0000_0000_8000_0000

`endif

// File: lsu_op_pkg.sv
// encodings are local to this unit and are not the RISC-V funct3 values
`default_nettype none

package lsu_op_pkg;

	// loads first, then stores
	typedef enum logic [3:0] {
		op_lb  = 4'd0,
		op_lh  = 4'd1,
		op_lw  = 4'd2,
		op_ld  = 4'd3,
		op_lbu = 4'd4,
		op_lhu = 4'd5,
		op_lwu = 4'd6,
		op_sb  = 4'd7,
		op_sh  = 4'd8,
		op_sw  = 4'd9,
		op_sd  = 4'd10
	} mem_op_e;

	typedef enum logic [1:0] {
		size_byte   = 2'd0,
		size_half   = 2'd1,
		size_word   = 2'd2,
		size_double = 2'd3
	} access_size_e;

endpackage

`default_nettype wire

// File: lsu_resp_pkg.sv
// one code per request; misaligned wins over out of range
`default_nettype none

package lsu_resp_pkg;

	typedef enum logic [1:0] {
		resp_ok           = 2'd0,
		resp_misaligned   = 2'd1,
		resp_out_of_range = 2'd2
	} resp_code_e;

endpackage

`default_nettype wire

// File: lsu_top.sv
// three registered stages; first response transfers three edges after acceptance
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_top
	import lsu_op_pkg::*, lsu_resp_pkg::*;
(
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  req_valid,
	output logic                 req_ready,
	input  wire mem_op_e         req_op,
	input  wire [`LSU_XLEN-1:0]  req_addr,
	input  wire [`LSU_XLEN-1:0]  req_wdata,
	output logic                 resp_valid,
	input  wire                  resp_ready,
	output logic [`LSU_XLEN-1:0] resp_data,
	output resp_code_e           resp_code
);

	logic                              al_valid;
	logic                              al_ready;
	mem_op_e                           al_op;
	logic [$clog2(`LSU_MEM_WORDS)-1:0] al_index;
	logic [2:0]                        al_offset;
	logic [`LSU_XLEN-1:0]              al_wdata;
	logic [`LSU_XLEN/8-1:0]            al_wmask;
	resp_code_e                        al_code;

	logic                              rd_valid;
	logic                              rd_ready;
	mem_op_e                           rd_op;
	logic [2:0]                        rd_offset;
	logic [`LSU_XLEN-1:0]              rd_word;
	resp_code_e                        rd_code;

	store_align store_align_inst (
		.clock, .reset,
		.req_valid, .req_ready, .req_op, .req_addr, .req_wdata,
		.al_valid, .al_ready, .al_op, .al_index, .al_offset, .al_wdata, .al_wmask, .al_code
	);

	data_ram data_ram_inst (
		.clock, .reset,
		.al_valid, .al_ready, .al_op, .al_index, .al_offset, .al_wdata, .al_wmask, .al_code,
		.rd_valid, .rd_ready, .rd_op, .rd_offset, .rd_word, .rd_code
	);

	load_extract load_extract_inst (
		.clock, .reset,
		.rd_valid, .rd_ready, .rd_op, .rd_offset, .rd_word, .rd_code,
		.resp_valid, .resp_ready, .resp_data, .resp_code
	);

endmodule

`default_nettype wire

// File: store_align.sv
// one slot; the range check uses the full address, al_index is cut to the RAM depth
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module store_align
	import lsu_op_pkg::*, lsu_resp_pkg::*;
(
	input  wire                               clock,
	input  wire                               reset,
	input  wire                               req_valid,
	input  wire mem_op_e                      req_op,
	input  wire [`LSU_XLEN-1:0]               req_addr,
	input  wire [`LSU_XLEN-1:0]               req_wdata,
	output logic                              req_ready,
	output logic                              al_valid,
	input  wire                               al_ready,
	output mem_op_e                           al_op,
	output logic [$clog2(`LSU_MEM_WORDS)-1:0] al_index,
	output logic [2:0]                        al_offset,
	output logic [`LSU_XLEN-1:0]              al_wdata,
	output logic [`LSU_XLEN/8-1:0]            al_wmask,
	output resp_code_e                        al_code
);

	localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

	access_size_e          size;
	logic [2:0]            align_mask;
	logic [`LSU_XLEN/8-1:0] size_be;
	logic                  is_store;
	logic [`LSU_XLEN-1:0]  rel_addr;
	logic [`LSU_XLEN-4:0]  word_idx;
	logic                  misaligned;
	logic                  out_of_range;
	resp_code_e            code;
	logic                  slot_full;

	always_comb begin
		case (req_op)
			op_lb, op_lbu, op_sb: size = size_byte;
			op_lh, op_lhu, op_sh: size = size_half;
			op_lw, op_lwu, op_sw: size = size_word;
			default:              size = size_double;
		endcase
	end

	// low address bits that must be zero, and byte enables before the shift
	always_comb begin
		case (size)
			size_byte: begin
				align_mask = 3'b000;
				size_be    = 8'h01;
			end
			size_half: begin
				align_mask = 3'b001;
				size_be    = 8'h03;
			end
			size_word: begin
				align_mask = 3'b011;
				size_be    = 8'h0f;
			end
			default: begin
				align_mask = 3'b111;
				size_be    = 8'hff;
			end
		endcase
	end

	assign is_store     = req_op inside {op_sb, op_sh, op_sw, op_sd};
	assign rel_addr     = req_addr - `LSU_MEM_BASE;
	assign word_idx     = rel_addr[`LSU_XLEN-1:3];
	assign misaligned   = |(req_addr[2:0] & align_mask);
	assign out_of_range = (req_addr < `LSU_MEM_BASE) || (word_idx >= `LSU_MEM_WORDS);

	always_comb begin
		if (misaligned)
			code = resp_misaligned;
		else if (out_of_range)
			code = resp_out_of_range;
		else
			code = resp_ok;
	end

	assign req_ready = !slot_full || al_ready;
	assign al_valid  = slot_full;

	always_ff @(posedge clock) begin
		if (reset) begin
			slot_full <= 1'b0;
		end else if (req_ready) begin
			slot_full <= req_valid;
		end
	end

	// store data and enables move up to the byte offset
	always_ff @(posedge clock) begin
		if (req_valid && req_ready) begin
			al_op     <= req_op;
			al_index  <= word_idx[IDX_W-1:0];
			al_offset <= req_addr[2:0];
			al_wdata  <= req_wdata << {req_addr[2:0], 3'b000};
			al_wmask  <= is_store ? size_be << req_addr[2:0] : '0;
			al_code   <= code;
		end
	end

	// slot contents held while the RAM stage stalls
	a_slot_hold: assert property (@(posedge clock) disable iff (reset)
		(al_valid && !al_ready) |=>
		(al_valid && $stable(al_op) && $stable(al_index) && $stable(al_offset)
			&& $stable(al_wdata) && $stable(al_wmask) && $stable(al_code)))
		else $error("store_align: slot changed while stalled");

endmodule

`default_nettype wire

// File: tb_lsu.sv
// RAM is filled before any load; random traffic stays in the filled region or just past its end
`timescale 1ns/1ps
`default_nettype none
`include "lsu_cfg.svh"

module tb_lsu
	import lsu_op_pkg::*, lsu_resp_pkg::*;
();

	localparam int WORDS = `LSU_MEM_WORDS;
	localparam int BYTE_W = $clog2(`LSU_MEM_WORDS * 8);
	localparam logic [`LSU_XLEN-1:0] BASE = `LSU_MEM_BASE;
	localparam int SEND_LIMIT = 200;
	localparam int DRAIN_LIMIT = 4000;

	logic                 clock;
	logic                 reset;
	logic                 req_valid;
	logic                 req_ready;
	mem_op_e              req_op;
	logic [`LSU_XLEN-1:0] req_addr;
	logic [`LSU_XLEN-1:0] req_wdata;
	logic                 resp_valid;
	logic                 resp_ready;
	logic [`LSU_XLEN-1:0] resp_data;
	resp_code_e           resp_code;

	logic [7:0]           ref_mem [WORDS*8];
	logic [`LSU_XLEN-1:0] exp_data_q [$];
	resp_code_e           exp_code_q [$];
	logic [31:0]          stim_lfsr;
	logic [31:0]          ready_lfsr;
	logic                 random_ready;
	int                   cycle;
	int                   errors;
	int                   timeouts;
	int                   last_accept;
	int                   last_resp;
	int                   resp_count;

	lsu_top lsu_top_inst (
		.clock, .reset,
		.req_valid, .req_ready, .req_op, .req_addr, .req_wdata,
		.resp_valid, .resp_ready, .resp_data, .resp_code
	);

	always #2 clock = ~clock;

	always @(posedge clock) cycle <= cycle + 1;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per bit
	task automatic take_bits(input int n, inout logic [31:0] state, output logic [63:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[62:0], state[0]};
			state = lfsr_next(state);
		end
	endtask

	function automatic int op_bytes(input mem_op_e op);
		case (op)
			op_lb, op_lbu, op_sb: return 1;
			op_lh, op_lhu, op_sh: return 2;
			op_lw, op_lwu, op_sw: return 4;
			default:              return 8;
		endcase
	endfunction

	function automatic logic [63:0] fill_pattern(input logic [63:0] addr);
		return (addr * 64'h9e37_79b9_7f4a_7c15) ^ {addr[31:0], addr[63:32]};
	endfunction

	// expected response from the byte model; stores update the model
	function automatic void model_access(input mem_op_e op, input logic [63:0] addr, wdata,
			output logic [63:0] data, output resp_code_e code);
		int              n;
		logic [63:0]     idx;
		logic [63:0]     val;
		logic [BYTE_W-1:0] bi;
		n = op_bytes(op);
		idx = addr - BASE;
		data = '0;
		val = '0;
		if (addr % 64'(n) != 0) begin
			code = resp_misaligned;
		end else if (addr < BASE || (idx >> 3) >= 64'(WORDS)) begin
			code = resp_out_of_range;
		end else begin
			code = resp_ok;
			for (int i = 0; i < n; i++) begin
				bi = idx[BYTE_W-1:0] + BYTE_W'(i);
				if (op inside {op_sb, op_sh, op_sw, op_sd})
					ref_mem[bi] = wdata[i*8 +: 8];
				else
					val[i*8 +: 8] = ref_mem[bi];
			end
			case (op)
				op_lb:                      data = {{56{val[7]}}, val[7:0]};
				op_lh:                      data = {{48{val[15]}}, val[15:0]};
				op_lw:                      data = {{32{val[31]}}, val[31:0]};
				op_sb, op_sh, op_sw, op_sd: data = '0;
				default:                    data = val;
			endcase
		end
	endfunction

	task automatic check_data(input logic [`LSU_XLEN-1:0] got, exp, input int num);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: response %0d data %h, expected %h", $time, num, got, exp);
		end
	endtask

	task automatic check_code(input resp_code_e got, exp, input int num);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: response %0d code %s, expected %s",
				$time, num, got.name(), exp.name());
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		timeouts++;
		$display("timeout: gave up waiting for %s", what);
		finish_run();
	endtask

	task automatic send(input mem_op_e op, input logic [63:0] addr, wdata);
		logic [63:0] data;
		resp_code_e  code;
		logic        ready_seen;
		int          waited;
		model_access(op, addr, wdata, data, code);
		exp_data_q.push_back(data);
		exp_code_q.push_back(code);
		@(negedge clock);
		req_valid = 1'b1;
		req_op = op;
		req_addr = addr;
		req_wdata = wdata;
		ready_seen = 1'b0;
		waited = 0;
		while (!ready_seen) begin
			if (waited == SEND_LIMIT)
				abort_on_timeout("req_ready to accept a request");
			#1;
			ready_seen = req_ready;
			last_accept = cycle + 1;
			@(posedge clock);
			waited++;
			if (!ready_seen)
				@(negedge clock);
		end
	endtask

	task automatic release_port(input int cycles);
		@(negedge clock);
		req_valid = 1'b0;
		repeat (cycles - 1) @(negedge clock);
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		release_port(1);
		while (exp_code_q.size() != 0) begin
			if (waited == DRAIN_LIMIT)
				abort_on_timeout("all outstanding responses");
			@(negedge clock);
			waited++;
		end
	endtask

	// pops one expectation per response transfer
	initial begin : compare
		logic [63:0] bits;
		logic [63:0] exp_data;
		resp_code_e  exp_code;
		forever begin
			@(negedge clock);
			if (random_ready) begin
				take_bits(2, ready_lfsr, bits);
				resp_ready = |bits[1:0];
			end else begin
				resp_ready = 1'b1;
			end
			#1;
			if (!reset && resp_valid && resp_ready) begin
				if (exp_code_q.size() == 0) begin
					errors++;
					$display("error at %0t ns: response with no request outstanding", $time);
				end else begin
					exp_data = exp_data_q.pop_front();
					exp_code = exp_code_q.pop_front();
					check_code(resp_code, exp_code, resp_count);
					check_data(resp_data, exp_data, resp_count);
					last_resp = cycle + 1;
				end
				resp_count++;
			end
		end
	end

	initial begin : stimulus
		logic [63:0] bits;
		logic [63:0] addr;
		logic [63:0] wdata;
		mem_op_e     op;
		int          first_accept;
		mem_op_e     ext_ops [6] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu};
		clock = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = op_ld;
		req_addr = BASE;
		req_wdata = '0;
		resp_ready = 1'b0;
		random_ready = 1'b0;
		stim_lfsr = 32'hd45;
		ready_lfsr = 32'hd45;
		cycle = 0;
		errors = 0;
		timeouts = 0;
		last_accept = 0;
		last_resp = 0;
		resp_count = 0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// fill every word, then read it back
		for (int w = 0; w < WORDS; w++) begin
			addr = BASE + 64'(w) * 64'd8;
			send(op_sd, addr, fill_pattern(addr));
		end
		for (int w = 0; w < WORDS; w++)
			send(op_ld, BASE + 64'(w) * 64'd8, '0);
		wait_drained();

		// sb, sh and sw merged into word 10
		for (int s = 0; s < 3; s++) begin
			for (int off = 0; off < 8; off += (1 << s)) begin
				op = (s == 0) ? op_sb : (s == 1) ? op_sh : op_sw;
				take_bits(64, stim_lfsr, wdata);
				send(op, BASE + 64'd80 + 64'(off), wdata);
				send(op_ld, BASE + 64'd80, '0);
			end
		end

		// every byte high bit set, then every byte high bit clear
		send(op_sd, BASE + 64'd160, 64'h8081_f0ff_c3a5_9ee7);
		send(op_sd, BASE + 64'd168, 64'h7f7e_0f00_3c5a_6118);
		for (int k = 0; k < 6; k++) begin
			for (int off = 0; off < 8; off += op_bytes(ext_ops[k])) begin
				send(ext_ops[k], BASE + 64'd160 + 64'(off), '0);
				send(ext_ops[k], BASE + 64'd168 + 64'(off), '0);
			end
		end

		// faults, then loads of the words they would have hit
		send(op_sh, BASE + 64'd33, 64'hdead_beef_dead_beef);
		send(op_sw, BASE + 64'd2, 64'h1111_2222_3333_4444);
		send(op_sd, BASE + 64'd4, 64'h5555_6666_7777_8888);
		send(op_ld, BASE + 64'd1, '0);
		send(op_lhu, BASE + 64'd7, '0);
		send(op_sd, BASE + 64'(WORDS) * 64'd8, 64'h9999_aaaa_bbbb_cccc);
		send(op_ld, BASE - 64'd8, '0);
		send(op_lb, 64'd0, '0);
		send(op_sh, BASE - 64'd1, 64'h0123_4567_89ab_cdef);
		send(op_sw, 64'hffff_ffff_ffff_fffc, 64'hfeed_face_feed_face);
		send(op_ld, BASE + 64'd32, '0);
		send(op_ld, BASE, '0);
		send(op_ld, BASE + 64'(WORDS - 1) * 64'd8, '0);
		wait_drained();

		// single load latency with resp_ready high
		send(op_ld, BASE + 64'd8, '0);
		wait_drained();
		if (last_resp - last_accept != 3) begin
			errors++;
			$display("error at %0t ns: single load took %0d cycles, expected 3",
				$time, last_resp - last_accept);
		end

		// back-to-back loads
		first_accept = 0;
		for (int i = 0; i < 8; i++) begin
			send(op_lbu, BASE + 64'd64 + 64'(i), '0);
			if (i == 0)
				first_accept = last_accept;
		end
		wait_drained();
		if (last_accept - first_accept != 7 || last_resp - last_accept != 3) begin
			errors++;
			$display("error at %0t ns: burst of 8 not accepted and answered one per cycle",
				$time);
		end

		// random traffic with stalls and gaps
		random_ready = 1'b1;
		for (int i = 0; i < 300; i++) begin
			take_bits(4, stim_lfsr, bits);
			op = mem_op_e'(bits[3:0] % 4'd11);
			take_bits(11, stim_lfsr, bits);
			addr = BASE + {53'b0, bits[10:0]};
			take_bits(3, stim_lfsr, bits);
			if (bits[2:0] == 3'd0)
				addr = addr + 64'(WORDS) * 64'd8;
			take_bits(64, stim_lfsr, wdata);
			send(op, addr, wdata);
			take_bits(2, stim_lfsr, bits);
			if (bits[1:0] == 2'd0)
				release_port(2);
		end
		wait_drained();
		finish_run();
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
lsu_op_pkg.sv
lsu_resp_pkg.sv
store_align.sv
data_ram.sv
load_extract.sv
lsu_top.sv
tb_lsu.sv
